// File: rtl/cachePkg.sv
package cachePkg;

    // Cache geometry
    localparam int lineOffsetBits = 7;
    localparam int wordsPerLine = 32;
    localparam int wordBits = 5;
    localparam int numSets = 8;
    localparam int setBits = 3;
    localparam int numWays = 4;
    localparam int wayBits = 2;
    localparam int tagBits = 32 - lineOffsetBits - setBits;
    localparam int lineAddrBits = tagBits + setBits;
    localparam int sramAddrBits = wayBits + setBits + lineOffsetBits;

    typedef enum logic [1:0] {
        memNone,
        memCacheToExt,
        memExtToCache
    } MemCmd;

    typedef struct packed {
        logic valid;
        logic isStore;
        logic [31:0] addr;
    } CacheReq;

    typedef struct packed {
        logic valid;
        logic isStore;
        logic [sramAddrBits-1:0] sramAddr;
    } CacheResp;

    // Addresses toward the memory controller are word addresses
    typedef struct packed {
        MemCmd cmd;
        logic [wayBits+setBits+wordBits-1:0] sramAddr;
        logic [lineAddrBits+wordBits-1:0] extAddr;
    } MemCtrl;

    typedef struct packed {
        logic busy;
        logic [wordBits:0] progress;
    } MemStat;

    typedef struct packed {
        logic [tagBits-1:0] tag;
        logic valid;
        logic dirty;
        logic used;
    } TagEntry;

    typedef struct packed {
        logic [wayBits-1:0] way;
        logic [setBits-1:0] set;
    } LineSlot;

endpackage

// File: rtl/tagTable.sv
`timescale 1ns/100ps

module tagTable (
    input  logic clk,
    input  logic rst,
    input  logic [31:0] lookupAddr,
    output logic hit,
    output logic [cachePkg::wayBits-1:0] hitWay,
    output logic freeAvail,
    output logic [cachePkg::wayBits-1:0] freeWay,
    output logic [cachePkg::wayBits-1:0] victimWay,
    output cachePkg::TagEntry victimEntry,
    input  logic touch,
    input  logic touchStore,
    input  logic [cachePkg::wayBits-1:0] touchWay,
    input  logic fillDone,
    input  cachePkg::LineSlot fillSlot,
    input  logic [cachePkg::tagBits-1:0] fillTag,
    input  logic inval,
    input  cachePkg::LineSlot invalSlot,
    input  cachePkg::LineSlot sweepSlot,
    output cachePkg::TagEntry sweepEntry
);
    import cachePkg::*;

    TagEntry entries [numSets][numWays];

    logic [setBits-1:0] lookupSet;
    logic [tagBits-1:0] lookupTag;

    assign lookupSet = lookupAddr[lineOffsetBits +: setBits];
    assign lookupTag = lookupAddr[31 -: tagBits];

    // Highest matching way wins in every scan
    always_comb begin
        hit = 1'b0;
        hitWay = '0;
        freeAvail = 1'b0;
        freeWay = '0;
        victimWay = '0;
        for (int w = 0; w < numWays; w++) begin
            if (entries[lookupSet][w].valid && entries[lookupSet][w].tag == lookupTag) begin
                hit = 1'b1;
                hitWay = wayBits'(w);
            end
            if (!entries[lookupSet][w].valid) begin
                freeAvail = 1'b1;
                freeWay = wayBits'(w);
            end
            if (!entries[lookupSet][w].used) begin
                victimWay = wayBits'(w);
            end
        end
    end

    assign victimEntry = entries[lookupSet][victimWay];
    assign sweepEntry = entries[sweepSlot.set][sweepSlot.way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < numSets; s++) begin
                for (int w = 0; w < numWays; w++) begin
                    entries[s][w].valid <= 1'b0;
                    entries[s][w].dirty <= 1'b0;
                    entries[s][w].used <= 1'b0;
                end
            end
        end else begin
            // Only the latest touched way keeps its used bit
            if (touch) begin
                for (int w = 0; w < numWays; w++) begin
                    entries[lookupSet][w].used <= 1'b0;
                end
                entries[lookupSet][touchWay].used <= 1'b1;
                if (touchStore) begin
                    entries[lookupSet][touchWay].dirty <= 1'b1;
                end
            end

            if (fillDone) begin
                entries[fillSlot.set][fillSlot.way].tag <= fillTag;
                entries[fillSlot.set][fillSlot.way].valid <= 1'b1;
                entries[fillSlot.set][fillSlot.way].dirty <= 1'b0;
            end

            if (inval) begin
                entries[invalSlot.set][invalSlot.way].valid <= 1'b0;
                entries[invalSlot.set][invalSlot.way].dirty <= 1'b0;
                entries[invalSlot.set][invalSlot.way].used <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/requestStage.sv
`timescale 1ns/100ps

module requestStage (
    input  logic clk,
    input  logic rst,
    input  cachePkg::CacheReq req,
    output logic stall,
    output cachePkg::CacheResp resp,
    input  logic flushBusy,
    input  logic engineIdle,
    output logic [31:0] lookupAddr,
    input  logic hit,
    input  logic [cachePkg::wayBits-1:0] hitWay,
    input  logic freeAvail,
    input  logic [cachePkg::wayBits-1:0] freeWay,
    input  logic [cachePkg::wayBits-1:0] victimWay,
    input  cachePkg::TagEntry victimEntry,
    output logic touch,
    output logic touchStore,
    output logic [cachePkg::wayBits-1:0] touchWay,
    output logic fillStart,
    output cachePkg::LineSlot fillSlot,
    output logic [cachePkg::lineAddrBits-1:0] fillAddr,
    output logic writeBack,
    output logic [cachePkg::lineAddrBits-1:0] wbAddr,
    output logic victimInval
);
    import cachePkg::*;

    logic [setBits-1:0] reqSet;
    logic accept;
    logic miss;

    assign lookupAddr = req.addr;
    assign reqSet = req.addr[lineOffsetBits +: setBits];

    assign accept = req.valid && hit && !flushBusy;
    assign miss = req.valid && !hit;

    // A missing request stays stalled until its line is installed
    assign stall = flushBusy || miss;

    assign touch = accept;
    assign touchStore = req.isStore;
    assign touchWay = hitWay;

    // Only one line transfer in flight
    assign fillStart = miss && !flushBusy && engineIdle;

    assign fillSlot = '{way: (freeAvail ? freeWay : victimWay), set: reqSet};
    assign fillAddr = req.addr[31:lineOffsetBits];

    // Victim is only used when the set has no free way
    assign writeBack = !freeAvail && victimEntry.valid && victimEntry.dirty;
    assign wbAddr = {victimEntry.tag, reqSet};
    assign victimInval = fillStart && !freeAvail;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp.valid <= 1'b0;
        end else begin
            resp.valid <= accept;
            if (accept) begin
                resp.isStore <= req.isStore;
                resp.sramAddr <= {hitWay, reqSet, req.addr[lineOffsetBits-1:0]};
            end
        end
    end

endmodule

// File: rtl/lineTransferFsm.sv
`timescale 1ns/100ps

module lineTransferFsm (
    input  logic clk,
    input  logic rst,
    input  logic fillStart,
    input  cachePkg::LineSlot fillSlot,
    input  logic [cachePkg::lineAddrBits-1:0] fillAddr,
    input  logic writeBack,
    input  logic [cachePkg::lineAddrBits-1:0] wbAddr,
    input  logic evictStart,
    input  cachePkg::LineSlot evictSlot,
    input  logic [cachePkg::lineAddrBits-1:0] evictAddr,
    output cachePkg::MemCtrl memCtrl,
    input  cachePkg::MemStat memStat,
    output logic idle,
    output logic fillDone,
    output cachePkg::LineSlot doneSlot,
    output logic [cachePkg::tagBits-1:0] doneTag
);
    import cachePkg::*;

    typedef enum logic [2:0] {
        stIdle,
        stEvictReq,
        stEvictActive,
        stLoadReq,
        stLoadActive,
        stReplaceReq,
        stReplaceActive
    } FsmState;

    FsmState state;
    logic [lineAddrBits-1:0] pendingAddr;
    logic xferDone;

    function automatic logic [wayBits+setBits+wordBits-1:0] slotBase(input LineSlot s);
        return {s.way, s.set, {wordBits{1'b0}}};
    endfunction

    assign xferDone = !memStat.busy || memStat.progress == wordsPerLine;
    assign idle = state == stIdle;

    // Install happens on the same edge that returns to idle
    assign fillDone = state == stLoadActive && xferDone;
    assign doneSlot = '{way: memCtrl.sramAddr[wordBits+setBits +: wayBits],
                        set: memCtrl.sramAddr[wordBits +: setBits]};
    assign doneTag = memCtrl.extAddr[wordBits+setBits +: tagBits];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            memCtrl.cmd <= memNone;
        end else begin
            case (state)
                stIdle: begin
                    if (fillStart) begin
                        memCtrl.sramAddr <= slotBase(fillSlot);
                        pendingAddr <= fillAddr;
                        if (writeBack) begin
                            memCtrl.cmd <= memCacheToExt;
                            memCtrl.extAddr <= {wbAddr, {wordBits{1'b0}}};
                            state <= stReplaceReq;
                        end else begin
                            memCtrl.cmd <= memExtToCache;
                            memCtrl.extAddr <= {fillAddr, {wordBits{1'b0}}};
                            state <= stLoadReq;
                        end
                    end else if (evictStart) begin
                        memCtrl.cmd <= memCacheToExt;
                        memCtrl.sramAddr <= slotBase(evictSlot);
                        memCtrl.extAddr <= {evictAddr, {wordBits{1'b0}}};
                        state <= stEvictReq;
                    end
                end
                stEvictReq: begin
                    if (memStat.busy) begin
                        memCtrl.cmd <= memNone;
                        state <= stEvictActive;
                    end
                end
                stLoadReq: begin
                    if (memStat.busy) begin
                        memCtrl.cmd <= memNone;
                        state <= stLoadActive;
                    end
                end
                stReplaceReq: begin
                    if (memStat.busy) begin
                        memCtrl.cmd <= memNone;
                        state <= stReplaceActive;
                    end
                end
                stEvictActive, stLoadActive: begin
                    if (xferDone) begin
                        state <= stIdle;
                    end
                end
                stReplaceActive: begin
                    // Refill goes to the slot just written back
                    if (xferDone) begin
                        memCtrl.cmd <= memExtToCache;
                        memCtrl.extAddr <= {pendingAddr, {wordBits{1'b0}}};
                        state <= stLoadReq;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// File: rtl/flushSequencer.sv
`timescale 1ns/100ps

module flushSequencer (
    input  logic clk,
    input  logic rst,
    input  logic fence,
    input  logic engineIdle,
    output logic fenceBusy,
    output cachePkg::LineSlot sweepSlot,
    input  cachePkg::TagEntry sweepEntry,
    output logic evictStart,
    output cachePkg::LineSlot evictSlot,
    output logic [cachePkg::lineAddrBits-1:0] evictAddr,
    output logic inval,
    output cachePkg::LineSlot invalSlot
);
    import cachePkg::*;

    logic busyReg;
    logic started;
    logic [setBits+wayBits:0] slotCnt;
    logic sweepDone;
    logic needWb;
    logic stepOk;

    assign fenceBusy = busyReg || fence;

    // Set-major order with the ways walking fastest
    assign sweepSlot = '{way: slotCnt[wayBits-1:0], set: slotCnt[wayBits +: setBits]};
    assign sweepDone = slotCnt[setBits+wayBits];

    assign needWb = sweepEntry.valid && sweepEntry.dirty;
    assign stepOk = started && !sweepDone && (!needWb || engineIdle);

    assign evictStart = stepOk && needWb;
    assign evictSlot = sweepSlot;
    assign evictAddr = {sweepEntry.tag, sweepSlot.set};
    assign inval = stepOk;
    assign invalSlot = sweepSlot;

    always_ff @(posedge clk) begin
        if (rst) begin
            busyReg <= 1'b0;
            started <= 1'b0;
            slotCnt <= '0;
        end else if (fence) begin
            busyReg <= 1'b1;
            started <= 1'b0;
            slotCnt <= '0;
        end else if (busyReg) begin
            // Let a pending refill land before sweeping
            if (!started) begin
                started <= engineIdle;
            end else if (sweepDone) begin
                if (engineIdle) begin
                    busyReg <= 1'b0;
                    started <= 1'b0;
                end
            end else if (stepOk) begin
                slotCnt <= slotCnt + 1'b1;
            end
        end
    end

endmodule

// File: rtl/cacheController.sv
`timescale 1ns/100ps

module cacheController (
    input  logic clk,
    input  logic rst,
    input  cachePkg::CacheReq req,
    output logic stall,
    output cachePkg::CacheResp resp,
    output cachePkg::MemCtrl memCtrl,
    input  cachePkg::MemStat memStat,
    input  logic fence,
    output logic fenceBusy
);
    import cachePkg::*;

    logic [31:0] lookupAddr;
    logic hit;
    logic [wayBits-1:0] hitWay;
    logic freeAvail;
    logic [wayBits-1:0] freeWay;
    logic [wayBits-1:0] victimWay;
    TagEntry victimEntry;
    logic touch;
    logic touchStore;
    logic [wayBits-1:0] touchWay;

    logic fillStart;
    LineSlot missSlot;
    logic [lineAddrBits-1:0] fillAddr;
    logic writeBack;
    logic [lineAddrBits-1:0] wbAddr;
    logic victimInval;

    logic engineIdle;
    logic fillDone;
    LineSlot doneSlot;
    logic [tagBits-1:0] doneTag;

    LineSlot sweepSlot;
    TagEntry sweepEntry;
    logic evictStart;
    LineSlot evictSlot;
    logic [lineAddrBits-1:0] evictAddr;
    logic flushInval;
    LineSlot flushInvalSlot;

    logic tblInval;
    LineSlot tblInvalSlot;

    // Victim and sweep invalidations never coincide
    assign tblInval = victimInval || flushInval;
    assign tblInvalSlot = flushInval ? flushInvalSlot : missSlot;

    tagTable i_tagTable (
        .clk(clk), .rst(rst), .lookupAddr(lookupAddr), .hit(hit), .hitWay(hitWay),
        .freeAvail(freeAvail), .freeWay(freeWay), .victimWay(victimWay),
        .victimEntry(victimEntry), .touch(touch), .touchStore(touchStore),
        .touchWay(touchWay), .fillDone(fillDone), .fillSlot(doneSlot), .fillTag(doneTag),
        .inval(tblInval), .invalSlot(tblInvalSlot), .sweepSlot(sweepSlot),
        .sweepEntry(sweepEntry)
    );

    requestStage i_requestStage (
        .clk(clk), .rst(rst), .req(req), .stall(stall), .resp(resp),
        .flushBusy(fenceBusy), .engineIdle(engineIdle), .lookupAddr(lookupAddr),
        .hit(hit), .hitWay(hitWay), .freeAvail(freeAvail), .freeWay(freeWay),
        .victimWay(victimWay), .victimEntry(victimEntry), .touch(touch),
        .touchStore(touchStore), .touchWay(touchWay), .fillStart(fillStart),
        .fillSlot(missSlot), .fillAddr(fillAddr), .writeBack(writeBack), .wbAddr(wbAddr),
        .victimInval(victimInval)
    );

    lineTransferFsm i_lineTransferFsm (
        .clk(clk), .rst(rst), .fillStart(fillStart), .fillSlot(missSlot),
        .fillAddr(fillAddr), .writeBack(writeBack), .wbAddr(wbAddr),
        .evictStart(evictStart), .evictSlot(evictSlot), .evictAddr(evictAddr),
        .memCtrl(memCtrl), .memStat(memStat), .idle(engineIdle), .fillDone(fillDone),
        .doneSlot(doneSlot), .doneTag(doneTag)
    );

    flushSequencer i_flushSequencer (
        .clk(clk), .rst(rst), .fence(fence), .engineIdle(engineIdle),
        .fenceBusy(fenceBusy), .sweepSlot(sweepSlot), .sweepEntry(sweepEntry),
        .evictStart(evictStart), .evictSlot(evictSlot), .evictAddr(evictAddr),
        .inval(flushInval), .invalSlot(flushInvalSlot)
    );

endmodule

// File: verif/cacheController_sva.sv
`timescale 1ns/100ps

module cacheController_sva (
    input logic clk,
    input logic rst,
    input logic stall,
    input cachePkg::CacheResp resp,
    input cachePkg::MemCtrl memCtrl,
    input cachePkg::MemStat memStat,
    input logic fenceBusy
);
    import cachePkg::*;

    int failCount = 0;

    // Command is held until the responder raises busy
    cmdHeld: assert property (@(posedge clk) disable iff (rst)
        memCtrl.cmd != memNone && !memStat.busy |=> $stable(memCtrl))
    else begin
        failCount++;
        $error("memory command changed before busy was seen");
    end

    stallDuringFence: assert property (@(posedge clk) disable iff (rst)
        fenceBusy |-> stall)
    else begin
        failCount++;
        $error("stall low while the fence sweep is busy");
    end

    // Nothing is taken while stalled
    noRespAfterStall: assert property (@(posedge clk) disable iff (rst)
        stall |=> !resp.valid)
    else begin
        failCount++;
        $error("response valid after a stalled cycle");
    end

endmodule

// File: verif/cacheRefModel.svh
`ifndef CACHE_REF_MODEL_SVH
`define CACHE_REF_MODEL_SVH

// Expected table state indexed by set and way
logic [tagBits-1:0] refTag [numSets][numWays];
logic refValid [numSets][numWays];
logic refDirty [numSets][numWays];
logic refUsed [numSets][numWays];

function automatic void clearTable();
    for (int s = 0; s < numSets; s++) begin
        for (int w = 0; w < numWays; w++) begin
            refTag[s][w] = '0;
            refValid[s][w] = 1'b0;
            refDirty[s][w] = 1'b0;
            refUsed[s][w] = 1'b0;
        end
    end
endfunction

function automatic logic lookupWay(input logic [setBits-1:0] set,
                                   input logic [tagBits-1:0] tag,
                                   output logic [wayBits-1:0] way);
    logic found;
    found = 1'b0;
    way = '0;
    for (int w = 0; w < numWays; w++) begin
        if (refValid[set][w] && refTag[set][w] == tag) begin
            found = 1'b1;
            way = wayBits'(w);
        end
    end
    return found;
endfunction

// Highest invalid way is filled first
function automatic logic freeWayOf(input logic [setBits-1:0] set,
                                   output logic [wayBits-1:0] way);
    logic found;
    found = 1'b0;
    way = '0;
    for (int w = 0; w < numWays; w++) begin
        if (!refValid[set][w]) begin
            found = 1'b1;
            way = wayBits'(w);
        end
    end
    return found;
endfunction

// Highest way with its used bit clear or way 0 when none is clear
function automatic logic [wayBits-1:0] victimOf(input logic [setBits-1:0] set);
    logic [wayBits-1:0] way;
    way = '0;
    for (int w = 0; w < numWays; w++) begin
        if (!refUsed[set][w]) begin
            way = wayBits'(w);
        end
    end
    return way;
endfunction

function automatic void touchLine(input logic [setBits-1:0] set,
                                  input logic [wayBits-1:0] way, input logic isStore);
    for (int w = 0; w < numWays; w++) begin
        refUsed[set][w] = 1'b0;
    end
    refUsed[set][way] = 1'b1;
    if (isStore) begin
        refDirty[set][way] = 1'b1;
    end
endfunction

function automatic void installLine(input logic [setBits-1:0] set,
                                    input logic [wayBits-1:0] way,
                                    input logic [tagBits-1:0] tag);
    refTag[set][way] = tag;
    refValid[set][way] = 1'b1;
    refDirty[set][way] = 1'b0;
endfunction

function automatic void invalidateLine(input logic [setBits-1:0] set,
                                       input logic [wayBits-1:0] way);
    refValid[set][way] = 1'b0;
    refDirty[set][way] = 1'b0;
    refUsed[set][way] = 1'b0;
endfunction

`endif

// File: verif/cacheControllerTb.sv
`timescale 1ns/100ps

module cacheControllerTb;
    import cachePkg::*;

    localparam int randomReqs = 150;
    localparam int rounds = 2;
    localparam int tagPool = 6;
    localparam int cycleLimit = rounds * (randomReqs + numSets * numWays) * 40
                                + rounds * 2000 + 100;

    logic clk;
    logic rst;
    CacheReq req;
    logic stall;
    CacheResp resp;
    MemCtrl memCtrl;
    MemStat memStat;
    logic fence;
    logic fenceBusy;

    integer seed;
    int cycleCount;
    int checkCount;
    int errorCount;
    int testCount;
    int checksAtStart;
    int errorsAtStart;
    int hitCount;
    int missCount;
    int replaceCount;
    int rspDelay;
    logic rspWaiting;
    logic [tagBits-1:0] tagBase [tagPool];
    MemCtrl cmdLog [$];
    MemCtrl expectLog [$];

    `include "cacheRefModel.svh"

    cacheController i_dut (
        .clk(clk), .rst(rst), .req(req), .stall(stall), .resp(resp), .memCtrl(memCtrl),
        .memStat(memStat), .fence(fence), .fenceBusy(fenceBusy)
    );

    bind cacheController cacheController_sva i_sva (
        .clk(clk), .rst(rst), .stall(stall), .resp(resp), .memCtrl(memCtrl),
        .memStat(memStat), .fenceBusy(fenceBusy)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Test FAILED");
            $finish;
        end
    end

    // Memory responder raising busy 1 to 3 cycles after a new command
    always @(posedge clk) begin
        if (rst) begin
            memStat <= '0;
            rspWaiting <= 1'b0;
            rspDelay <= 0;
        end else if (memStat.busy) begin
            if (memStat.progress == wordsPerLine - 1) begin
                memStat.busy <= 1'b0;
            end
            memStat.progress <= memStat.progress + 1'b1;
        end else if (rspWaiting) begin
            if (rspDelay <= 1) begin
                memStat.busy <= 1'b1;
                memStat.progress <= '0;
                rspWaiting <= 1'b0;
            end else begin
                rspDelay <= rspDelay - 1;
            end
        end else if (memCtrl.cmd != memNone) begin
            cmdLog.push_back(memCtrl);
            rspWaiting <= 1'b1;
            rspDelay <= 1 + cmdLog.size() % 3;
        end
    end

    task automatic expectEqual(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("mismatch %s: got %0h, expected %0h", name, got, expected);
        end
    endtask

    task automatic startTest();
        checksAtStart = checkCount;
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest(input string name, input string detail);
        testCount++;
        $display("%s: %s, %0d checks, %0d errors", name, detail,
                 checkCount - checksAtStart, errorCount - errorsAtStart);
    endtask

    task automatic compareCommands(input int logStart);
        int seen;
        seen = cmdLog.size() - logStart;
        checkCount++;
        if (seen != expectLog.size()) begin
            errorCount++;
            $display("memory controller got %0d commands where %0d were expected",
                     seen, expectLog.size());
        end else begin
            for (int i = 0; i < seen; i++) begin
                expectEqual("memCtrl.cmd", cmdLog[logStart + i].cmd, expectLog[i].cmd);
                expectEqual("memCtrl.sramAddr", cmdLog[logStart + i].sramAddr,
                            expectLog[i].sramAddr);
                expectEqual("memCtrl.extAddr", cmdLog[logStart + i].extAddr,
                            expectLog[i].extAddr);
            end
        end
    endtask

    // One request from drive to response with the model updated alongside
    task automatic issueRequest(input logic [31:0] addr, input logic isStore);
        logic [setBits-1:0] set;
        logic [tagBits-1:0] tag;
        logic [wayBits-1:0] way;
        logic isHit;
        int logStart;
        MemCtrl expCmd;
        set = addr[lineOffsetBits +: setBits];
        tag = addr[31 -: tagBits];
        logStart = cmdLog.size();
        expectLog.delete();
        isHit = lookupWay(set, tag, way);
        if (isHit) begin
            hitCount++;
        end else begin
            missCount++;
            if (!freeWayOf(set, way)) begin
                way = victimOf(set);
                if (refValid[set][way] && refDirty[set][way]) begin
                    expCmd.cmd = memCacheToExt;
                    expCmd.sramAddr = {way, set, {wordBits{1'b0}}};
                    expCmd.extAddr = {refTag[set][way], set, {wordBits{1'b0}}};
                    expectLog.push_back(expCmd);
                    replaceCount++;
                end
                invalidateLine(set, way);
            end
            expCmd.cmd = memExtToCache;
            expCmd.sramAddr = {way, set, {wordBits{1'b0}}};
            expCmd.extAddr = {addr[31:lineOffsetBits], {wordBits{1'b0}}};
            expectLog.push_back(expCmd);
            installLine(set, way, tag);
        end
        touchLine(set, way, isStore);

        req <= '{valid: 1'b1, isStore: isStore, addr: addr};
        @(posedge clk);
        expectEqual("stall", stall, !isHit);
        while (stall) begin
            @(posedge clk);
        end
        req.valid <= 1'b0;
        @(posedge clk);
        expectEqual("resp.valid", resp.valid, 1'b1);
        expectEqual("resp.isStore", resp.isStore, isStore);
        expectEqual("resp.sramAddr", resp.sramAddr, {way, set, addr[lineOffsetBits-1:0]});
        compareCommands(logStart);
    endtask

    task automatic randomTraffic(input string name, input int count);
        logic [31:0] addr;
        int r;
        startTest();
        hitCount = 0;
        missCount = 0;
        replaceCount = 0;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            addr = {tagBase[r[15:0] % tagPool], r[18:16], r[26:20]};
            issueRequest(addr, r[31]);
        end
        checkCount++;
        if (replaceCount == 0) begin
            errorCount++;
            $display("%s never evicted a dirty line", name);
        end
        finishTest(name, $sformatf("%0d hits, %0d misses, %0d dirty replaces",
                                   hitCount, missCount, replaceCount));
    endtask

    task automatic fenceSweep(input string name);
        logic [31:0] oldAddrs [$];
        MemCtrl expCmd;
        int logStart;
        int wbCount;
        startTest();
        expectLog.delete();
        // Write-backs come in set-major slot order
        for (int s = 0; s < numSets; s++) begin
            for (int w = 0; w < numWays; w++) begin
                if (refValid[s][w]) begin
                    oldAddrs.push_back({refTag[s][w], 3'(s), 7'h0});
                end
                if (refValid[s][w] && refDirty[s][w]) begin
                    expCmd.cmd = memCacheToExt;
                    expCmd.sramAddr = {2'(w), 3'(s), {wordBits{1'b0}}};
                    expCmd.extAddr = {refTag[s][w], 3'(s), {wordBits{1'b0}}};
                    expectLog.push_back(expCmd);
                end
            end
        end
        wbCount = expectLog.size();
        clearTable();
        logStart = cmdLog.size();

        fence <= 1'b1;
        @(posedge clk);
        expectEqual("fenceBusy", fenceBusy, 1'b1);
        expectEqual("stall", stall, 1'b1);
        fence <= 1'b0;
        while (fenceBusy) begin
            @(posedge clk);
        end
        compareCommands(logStart);

        // Each old line must miss again
        foreach (oldAddrs[i]) begin
            issueRequest(oldAddrs[i], 1'b0);
        end
        finishTest(name, $sformatf("%0d write-backs, %0d old lines refetched",
                                   wbCount, oldAddrs.size()));
    endtask

    initial begin
        int r;
        seed = 32'h104e_65e2;
        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        fence = 1'b0;
        memStat = '0;
        cycleCount = 0;
        checkCount = 0;
        errorCount = 0;
        testCount = 0;
        for (int i = 0; i < tagPool; i++) begin
            r = $random(seed);
            tagBase[i] = {r[18:0], 3'(i)};
        end
        clearTable();

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        startTest();
        expectEqual("stall", stall, 1'b0);
        expectEqual("resp.valid", resp.valid, 1'b0);
        expectEqual("memCtrl.cmd", memCtrl.cmd, memNone);
        expectEqual("fenceBusy", fenceBusy, 1'b0);
        finishTest("reset", "idle outputs");

        for (int k = 0; k < rounds; k++) begin
            randomTraffic($sformatf("random round %0d", k), randomReqs);
            fenceSweep($sformatf("fence round %0d", k));
        end

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 testCount, checkCount, errorCount, i_dut.i_sva.failCount);
        if (errorCount == 0 && i_dut.i_sva.failCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+verif
rtl/cachePkg.sv
rtl/tagTable.sv
rtl/requestStage.sv
rtl/lineTransferFsm.sv
rtl/flushSequencer.sv
rtl/cacheController.sv
verif/cacheController_sva.sv
verif/cacheControllerTb.sv
